// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, starts low
    always #(period / 2) clk = ~clk;

endmodule

// File: dv/tcp_tx_tb.sv
`timescale 1ns/10ps

module tcp_tx_tb;

    // connection under test
    localparam logic [47:0] local_mac      = 48'h02_11_22_33_44_55;
    localparam logic [47:0] remote_mac     = 48'h02_66_77_88_99_AA;
    localparam logic [31:0] local_ip       = {8'd10, 8'd0, 8'd0, 8'd1};
    localparam logic [31:0] remote_ip      = {8'd10, 8'd0, 8'd0, 8'd2};
    localparam logic [15:0] local_port     = 16'd5001;
    localparam logic [15:0] remote_port    = 16'd80;
    localparam logic [31:0] recon_interval = 32'd40;

    localparam logic [11:0] rst_flag = 12'h004;
    localparam logic [11:0] syn_flag = 12'h002;

    localparam int n_tests      = 6;
    localparam int quiet_cycles = 60;
    localparam int reset_cycles = 3;

    typedef struct packed {
        int        phy_on;
        int        drop_frame;
        int        drop_beat;
        int        duty;
        int        frames;
        bit [15:0] syn_mask;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    logic        phy_ready;
    logic        net_ready;
    logic [63:0] net_data;
    logic        net_valid;
    logic [2:0]  net_cnt;
    logic        net_fin;

    test_row_t   row;
    int          cur_test;
    int          test_frames;
    int          beat_no;
    logic        drop_req;
    logic [11:0] frame_flags;
    logic [15:0] model_ident;
    logic [31:0] model_seq;
    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          tests_failed;

    tb_clock_gen #(
        .period(10)
    ) u_clock (
        .clk(clk)
    );

    tcp_tx_top #(
        .local_mac     (local_mac),
        .remote_mac    (remote_mac),
        .local_ip      (local_ip),
        .remote_ip     (remote_ip),
        .local_port    (local_port),
        .remote_port   (remote_port),
        .recon_interval(recon_interval)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .phy_ready(phy_ready),
        .net_data (net_data),
        .net_valid(net_valid),
        .net_ready(net_ready),
        .net_cnt  (net_cnt),
        .net_fin  (net_fin)
    );

    // phy on, drop frame, drop beat, ready duty %, frames, syn mask (bit i = frame i+1)
    function automatic test_row_t table_row(input int t);
        test_row_t r;
        case (t)
            0: r = '{0, 0, 0, 100, 0, 16'b0};
            1: r = '{1, 5, 1, 100, 6, 16'b10_1010};
            2: r = '{1, 2, 3, 100, 2, 16'b10};
            3: r = '{1, 3, 4, 60, 4, 16'b1010};
            4: r = '{1, 1, 7, 35, 2, 16'b10};
            5: r = '{1, 5, 2, 50, 6, 16'b10_1010};
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic string row_name(input int t);
        case (t)
            0: return "phy down after reset";
            1: return "rst and syn pairs at full rate";
            2: return "phy drop inside syn frame";
            3: return "phy drop mid rst frame, random ready";
            4: return "phy drop on last rst beat, slow sink";
            5: return "several pairs, random ready";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // end-around carry until 16 bits, then complement
    function automatic logic [15:0] fold_complement(input logic [31:0] acc);
        logic [31:0] s;
        s = acc;
        while (s[31:16] != 16'h0000) begin
            s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
        end
        return ~s[15:0];
    endfunction

    // reference beat, header fields written out from the protocol layout
    function automatic logic [63:0] expected_beat(input int idx, input logic [11:0] flags,
                                                  input logic [15:0] ident,
                                                  input logic [31:0] seq);
        logic [31:0] ip_acc;
        logic [31:0] tcp_acc;
        logic [15:0] ip_cs;
        logic [15:0] tcp_cs;
        // version/ihl/tos, length 40, id, df, ttl 64 + proto 6, addresses
        ip_acc = 32'h4500 + 32'd40 + {16'h0, ident} + 32'h4000 + 32'h4006
               + {16'h0, local_ip[31:16]} + {16'h0, local_ip[15:0]}
               + {16'h0, remote_ip[31:16]} + {16'h0, remote_ip[15:0]};
        // pseudo-header then header with zero ack, offset 5, window 512
        tcp_acc = {16'h0, local_ip[31:16]} + {16'h0, local_ip[15:0]}
                + {16'h0, remote_ip[31:16]} + {16'h0, remote_ip[15:0]}
                + 32'd6 + 32'd20 + {16'h0, local_port} + {16'h0, remote_port}
                + {16'h0, seq[31:16]} + {16'h0, seq[15:0]}
                + {16'h0, 4'h5, flags} + 32'd512;
        ip_cs  = fold_complement(ip_acc);
        tcp_cs = fold_complement(tcp_acc);
        case (idx)
            0: return {local_mac, remote_mac[47:32]};
            1: return {remote_mac[31:0], 16'h0800, 16'h4500};
            2: return {16'd40, ident, 16'h4000, 8'd64, 8'd6};
            3: return {ip_cs, local_ip, remote_ip[31:16]};
            4: return {remote_ip[15:0], local_port, remote_port, seq[31:16]};
            5: return {seq[15:0], 32'h0, 4'h5, flags};
            6: return {16'd512, tcp_cs, 16'h0000, 16'h0000};
            default: return 64'h0;
        endcase
    endfunction

    function automatic int watchdog_cycles();
        int        total;
        test_row_t r;
        total = reset_cycles + 100;
        for (int t = 0; t < n_tests; t++) begin
            r = table_row(t);
            total += quiet_cycles + int'(recon_interval);
            total += r.frames * (int'(recon_interval) + (7 * 300) / r.duty);
        end
        return total;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one beat that transfers on the coming edge
    task automatic take_beat();
        logic [63:0] exp_data;
        logic [63:0] keep;
        string       tag;
        if (beat_no == 0) begin
            frame_flags = rst_flag;
            if (test_frames < 16 && row.syn_mask[test_frames[3:0]]) begin
                frame_flags = syn_flag;
            end
        end
        exp_data = expected_beat(beat_no, frame_flags, model_ident, model_seq);
        // two pad bytes past cnt 5 are not part of the frame
        keep = (beat_no == 6) ? 64'hFFFF_FFFF_FFFF_0000 : '1;
        tag = $sformatf("test %0d frame %0d beat %0d", cur_test, test_frames + 1, beat_no + 1);
        check_value({tag, " data"}, net_data & keep, exp_data & keep);
        check_value({tag, " cnt"}, 64'(net_cnt), (beat_no == 6) ? 64'd5 : 64'd7);
        check_value({tag, " fin"}, 64'(net_fin), (beat_no == 6) ? 64'd1 : 64'd0);
        if (test_frames + 1 == row.drop_frame && beat_no + 1 == row.drop_beat) begin
            drop_req = 1'b1;
        end
        if (net_fin || beat_no == 6) begin
            model_ident = model_ident + 16'd1;
            // syn uses up one sequence number
            if (frame_flags == syn_flag) begin
                model_seq = model_seq + 32'd1;
            end
            test_frames++;
            beat_no = 0;
        end else begin
            beat_no++;
        end
    endtask

    task automatic run_test(input int t);
        int quiet;
        int errs_before;
        quiet = 0;
        errs_before = errors;
        cur_test = t;
        row = table_row(t);
        test_frames = 0;
        beat_no = 0;
        drop_req = 1'b0;
        while (quiet < quiet_cycles) begin
            @(posedge clk);
            #1;
            phy_ready = (row.phy_on != 0) && !drop_req;
            rng_state = xorshift32(rng_state);
            net_ready = (row.duty >= 100) || (int'(rng_state % 32'd100) < row.duty);
            if (row.phy_on == 0) begin
                check_value("net_valid with phy down", 64'(net_valid), 64'd0);
                check_value("net_fin with phy down", 64'(net_fin), 64'd0);
            end
            if (net_valid && net_ready) begin
                take_beat();
            end
            // all frames in and the stream gone idle
            if (test_frames >= row.frames && beat_no == 0 && !net_valid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        phy_ready = 1'b0;
        check_value($sformatf("test %0d frame count", t), 64'(test_frames), 64'(row.frames));
        if (errors == errs_before) begin
            $display("test %0d, %s: %0d frames, ok", t, row_name(t), test_frames);
        end else begin
            tests_failed++;
            $display("test %0d, %s: %0d frames, %0d errors", t, row_name(t), test_frames,
                     errors - errs_before);
        end
    endtask

    initial begin
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not end within %0d clock cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        phy_ready    = 1'b0;
        net_ready    = 1'b0;
        drop_req     = 1'b0;
        rng_state    = 32'd43;
        model_ident  = '0;
        model_seq    = '0;
        frame_flags  = '0;
        cur_test     = 0;
        checks       = 0;
        errors       = 0;
        tests_failed = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/tcp_tx_pkg.sv
rtl/ones_complement_sum.sv
rtl/conn_controller.sv
rtl/segment_generator.sv
rtl/tcp_tx_top.sv
dv/tb_clock_gen.sv
dv/tcp_tx_tb.sv

// File: rtl/conn_controller.sv
`timescale 1ns/10ps

module conn_controller #(
    parameter logic [31:0] recon_interval = 32'd100_000_000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   phy_ready,
    output logic                   seg_trg,
    output tcp_tx_pkg::tcp_flags_t seg_flags,
    input  logic                   seg_ack
);

    import tcp_tx_pkg::*;

    typedef enum logic {
        st_wait_rst,
        st_syn_pending
    } conn_state_t;

    conn_state_t state;
    logic [31:0] recon_cnt;
    logic        req_free;

    // next request may be placed in the cycle the current one is taken
    assign req_free = !seg_trg || seg_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_wait_rst;
            seg_trg   <= 1'b0;
            seg_flags <= '0;
            recon_cnt <= '0;
        end else begin
            if (seg_ack) begin
                seg_trg <= 1'b0;
            end

            // reconnect countdown runs every cycle
            if (recon_cnt != '0) begin
                recon_cnt <= recon_cnt - 32'd1;
            end

            if (req_free) begin
                case (state)
                    st_wait_rst: begin
                        // only start a new attempt while the link is up
                        if (phy_ready && recon_cnt == '0) begin
                            seg_trg   <= 1'b1;
                            seg_flags <= flag_rst;
                            recon_cnt <= recon_interval;
                            state     <= st_syn_pending;
                        end
                    end
                    st_syn_pending: begin
                        // syn always follows the rst it belongs to
                        seg_trg   <= 1'b1;
                        seg_flags <= flag_syn;
                        state     <= st_wait_rst;
                    end
                    default: begin
                        state <= st_wait_rst;
                    end
                endcase
            end
        end
    end

    // request held with the same flags until the generator takes it
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        seg_trg && !seg_ack |=> seg_trg && $stable(seg_flags)
    );

endmodule

// File: rtl/ones_complement_sum.sv
`timescale 1ns/10ps

module ones_complement_sum #(
    parameter int n_words = 2
) (
    input  logic [15:0] words [n_words],
    output logic [15:0] sum
);

    // room for every carry out of bit 15
    localparam int acc_w = 16 + $clog2(n_words + 1);

    logic [acc_w-1:0] acc;
    logic [16:0]      fold;

    // plain binary sum of all words
    always_comb begin
        acc = '0;
        for (int i = 0; i < n_words; i++) begin
            acc = acc + acc_w'(words[i]);
        end
    end

    // end-around carry, first fold leaves at most one carry bit
    assign fold = 17'(acc[15:0]) + 17'(acc >> 16);

    // second fold cannot overflow again
    assign sum = fold[15:0] + 16'(fold[16]);

endmodule

// File: rtl/segment_generator.sv
`timescale 1ns/10ps

module segment_generator #(
    parameter logic [47:0] local_mac   = '0,
    parameter logic [47:0] remote_mac  = '0,
    parameter logic [31:0] local_ip    = '0,
    parameter logic [31:0] remote_ip   = '0,
    parameter logic [15:0] local_port  = '0,
    parameter logic [15:0] remote_port = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   seg_trg,
    input  tcp_tx_pkg::tcp_flags_t seg_flags,
    output logic                   seg_ack,
    output tcp_tx_pkg::net_word_t  net_data,
    output logic                   net_valid,
    input  logic                   net_ready,
    output tcp_tx_pkg::byte_cnt_t  net_cnt,
    output logic                   net_fin
);

    import tcp_tx_pkg::*;

    // beat loaded when the identification goes out and checksums latch
    localparam beat_idx_t idx_ident  = 3'd2;
    // beat carrying the low half of the sequence number
    localparam beat_idx_t idx_seq_lo = 3'd5;
    localparam beat_idx_t idx_last   = beat_idx_t'(hdr_beats - 1);

    // no receive path, so nothing is ever acknowledged
    localparam logic [31:0] ack_number = 32'd0;

    beat_idx_t   beat_idx;
    tcp_flags_t  flags_q;
    logic [15:0] ident;
    logic [31:0] seq_num;
    logic [15:0] ip_csum_q;
    logic [15:0] tcp_csum_q;
    logic [15:0] ip_sum;
    logic [15:0] tcp_sum;
    logic [15:0] ip_words [10];
    logic [15:0] tcp_words [16];
    net_word_t   next_data;
    logic        out_free;
    logic        accept;
    logic        beat_load;
    logic        syn_step;

    // output register can take a new beat
    assign out_free  = !net_valid || net_ready;
    // index 0 means idle, waiting for a request
    assign accept    = out_free && beat_idx == '0 && seg_trg;
    assign beat_load = out_free && (beat_idx != '0 || seg_trg);
    assign syn_step  = (flags_q & flag_syn) != '0;

    // ipv4 header words, checksum field as zero
    assign ip_words = '{
        ip_ver_ihl_tos, ip_total_len, ident, ip_flags_frag,
        {ip_ttl, ip_proto_tcp}, 16'h0000,
        local_ip[31:16], local_ip[15:0], remote_ip[31:16], remote_ip[15:0]
    };

    // pseudo-header then tcp header, checksum field as zero
    assign tcp_words = '{
        local_ip[31:16], local_ip[15:0], remote_ip[31:16], remote_ip[15:0],
        {8'h00, ip_proto_tcp}, tcp_hdr_len,
        local_port, remote_port, seq_num[31:16], seq_num[15:0],
        ack_number[31:16], ack_number[15:0], {tcp_data_offset, flags_q},
        tcp_window, 16'h0000, 16'h0000
    };

    ones_complement_sum #(
        .n_words(10)
    ) u_ip_sum (
        .words(ip_words),
        .sum  (ip_sum)
    );

    ones_complement_sum #(
        .n_words(16)
    ) u_tcp_sum (
        .words(tcp_words),
        .sum  (tcp_sum)
    );

    // header content of the beat about to be loaded
    always_comb begin
        case (beat_idx)
            3'd0: next_data = {local_mac, remote_mac[47:32]};
            3'd1: next_data = {remote_mac[31:0], ethertype_ipv4, ip_ver_ihl_tos};
            3'd2: next_data = {ip_total_len, ident, ip_flags_frag, ip_ttl, ip_proto_tcp};
            3'd3: next_data = {ip_csum_q, local_ip, remote_ip[31:16]};
            3'd4: next_data = {remote_ip[15:0], local_port, remote_port, seq_num[31:16]};
            3'd5: next_data = {seq_num[15:0], ack_number, tcp_data_offset, flags_q};
            // window, checksum, urgent pointer, two pad bytes
            3'd6: next_data = {tcp_window, tcp_csum_q, 16'h0000, 16'h0000};
            default: next_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx  <= '0;
            seg_ack   <= 1'b0;
            net_valid <= 1'b0;
            net_fin   <= 1'b0;
            ident     <= '0;
            seq_num   <= '0;
        end else begin
            seg_ack <= accept;
            if (beat_load) begin
                net_valid <= 1'b1;
                net_fin   <= beat_idx == idx_last;
                beat_idx  <= (beat_idx == idx_last) ? '0 : beat_idx + 3'd1;
                if (beat_idx == idx_ident) begin
                    ident <= ident + 16'd1;
                end
                // syn takes one sequence number, rst none
                if (beat_idx == idx_seq_lo) begin
                    seq_num <= seq_num + 32'(syn_step);
                end
            end else if (net_ready) begin
                net_valid <= 1'b0;
                net_fin   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            flags_q <= seg_flags;
        end
        if (beat_load) begin
            net_data <= next_data;
            net_cnt  <= (beat_idx == idx_last) ? last_beat_cnt : '1;
        end
        // both sums settle well before beats 4 and 7
        if (beat_load && beat_idx == idx_ident) begin
            ip_csum_q  <= ~ip_sum;
            tcp_csum_q <= ~tcp_sum;
        end
    end

    // beat held while the sink stalls
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        net_valid && !net_ready |=>
            net_valid && $stable(net_data) && $stable(net_cnt) && $stable(net_fin)
    );

    // frame end only on the short final beat
    a_fin_cnt: assert property (
        @(posedge clk) disable iff (!rst_n)
        net_valid && net_fin |-> net_cnt == last_beat_cnt
    );

endmodule

// File: rtl/tcp_tx_pkg.sv
package tcp_tx_pkg;

    // one 64-bit beat of the MAC stream
    typedef logic [63:0] net_word_t;

    // index of the last valid byte in a beat, 7 for a full beat
    typedef logic [2:0] byte_cnt_t;

    // reserved bits and flags below the data offset
    typedef logic [11:0] tcp_flags_t;

    // position of a beat inside the header frame
    typedef logic [2:0] beat_idx_t;

    // tcp control flags
    localparam tcp_flags_t flag_rst = 12'h004;
    localparam tcp_flags_t flag_syn = 12'h002;

    // ethernet
    localparam logic [15:0] ethertype_ipv4 = 16'h0800;

    // ipv4 header fields
    localparam logic [15:0] ip_ver_ihl_tos = 16'h4500;
    localparam logic [15:0] ip_flags_frag  = 16'h4000;
    localparam logic [7:0]  ip_ttl         = 8'd64;
    localparam logic [7:0]  ip_proto_tcp   = 8'd6;

    // 20 bytes ipv4 plus 20 bytes tcp, no payload
    localparam logic [15:0] ip_total_len = 16'd40;

    // tcp header fields
    localparam logic [15:0] tcp_hdr_len     = 16'd20;
    localparam logic [3:0]  tcp_data_offset = 4'd5;
    localparam logic [15:0] tcp_window      = 16'd512;

    // 54 header bytes over 64-bit beats
    localparam int hdr_beats = 7;

    // six bytes valid in the final beat
    localparam byte_cnt_t last_beat_cnt = 3'd5;

endpackage

// File: rtl/tcp_tx_top.sv
`timescale 1ns/10ps

module tcp_tx_top #(
    parameter logic [47:0] local_mac      = 48'h06_00_AA_BB_CC_DD,
    parameter logic [47:0] remote_mac     = 48'h06_00_AA_BB_CC_DE,
    parameter logic [31:0] local_ip       = {8'd192, 8'd168, 8'd2, 8'd240},
    parameter logic [31:0] remote_ip      = {8'd192, 8'd168, 8'd2, 8'd241},
    parameter logic [15:0] local_port     = 16'd12345,
    parameter logic [15:0] remote_port    = 16'd23456,
    parameter logic [31:0] recon_interval = 32'd100_000_000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  phy_ready,
    output tcp_tx_pkg::net_word_t net_data,
    output logic                  net_valid,
    input  logic                  net_ready,
    output tcp_tx_pkg::byte_cnt_t net_cnt,
    output logic                  net_fin
);

    import tcp_tx_pkg::*;

    // request handshake between controller and generator
    logic       seg_trg;
    tcp_flags_t seg_flags;
    logic       seg_ack;

    conn_controller #(
        .recon_interval(recon_interval)
    ) u_conn_controller (
        .clk      (clk),
        .rst_n    (rst_n),
        .phy_ready(phy_ready),
        .seg_trg  (seg_trg),
        .seg_flags(seg_flags),
        .seg_ack  (seg_ack)
    );

    segment_generator #(
        .local_mac  (local_mac),
        .remote_mac (remote_mac),
        .local_ip   (local_ip),
        .remote_ip  (remote_ip),
        .local_port (local_port),
        .remote_port(remote_port)
    ) u_segment_generator (
        .clk      (clk),
        .rst_n    (rst_n),
        .seg_trg  (seg_trg),
        .seg_flags(seg_flags),
        .seg_ack  (seg_ack),
        .net_data (net_data),
        .net_valid(net_valid),
        .net_ready(net_ready),
        .net_cnt  (net_cnt),
        .net_fin  (net_fin)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the tcp transmit testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module tcp_tx_tb \
    -Mdir obj_dir \
    -o tcp_tx_sim

sim_out=$(./obj_dir/tcp_tx_sim)
printf '%s\n' "$sim_out"

if grep -qxF '** PASS **' <<< "$sim_out"; then
    exit 0
fi
exit 1
